// File: hdl/mask_unit.sv
`default_nettype none

module mask_unit import vex_pkg::*; (
    input  logic [vlen-1:0]      v0,
    input  logic                 mask_enable,
    input  logic [1:0]           bank_offset,
    input  logic [7:0]           vl,
    output logic [num_lanes-1:0] lane_mask
);

    for (genvar k = 0; k < num_lanes; k++) begin : g_lane
        logic [3:0] idx;
        logic       in_body;
        logic       v0_ok;

        assign idx = {bank_offset, 2'(k)};

        // Tail elements past vl stay untouched
        assign in_body = {4'b0000, idx} < vl;
        assign v0_ok   = !mask_enable || v0[idx];

        assign lane_mask[k] = in_body && v0_ok;
    end

endmodule

`default_nettype wire

// File: hdl/read_xbar.sv
`default_nettype none

module read_xbar import vex_pkg::*; (
    input  logic        CLK,
    input  logic [31:0] bank_dat [num_lanes],
    input  logic [1:0]  veew,
    input  logic [1:0]  bank_offset,
    input  logic        sign_ext,
    output logic [31:0] out_dat [num_lanes]
);

    logic offset_ok;

    for (genvar k = 0; k < num_lanes; k++) begin : g_lane
        // Element index of this lane within the register
        logic [3:0] idx;
        logic [1:0] bsel;
        bank_word_u word;

        assign idx = {bank_offset, 2'(k)};

        always_comb begin
            case (veew)
                eew_8:   bsel = idx[3:2];
                eew_16:  bsel = idx[2:1];
                default: bsel = idx[1:0];
            endcase
            word.word = bank_dat[bsel];
            case (veew)
                eew_8:
                    out_dat[k] = {{24{sign_ext & word.bytes[idx[1:0]][7]}},
                                  word.bytes[idx[1:0]]};
                eew_16:
                    out_dat[k] = {{16{sign_ext & word.halves[idx[0]][15]}},
                                  word.halves[idx[0]]};
                eew_32:  out_dat[k] = word.word;
                default: out_dat[k] = '0;
            endcase
        end
    end

    assign offset_ok = (veew == eew_8) ||
                       (veew == eew_16 && !bank_offset[1]) ||
                       (veew == eew_32 && bank_offset == 2'd0);

    assert property (@(posedge CLK) offset_ok)
        else $error("bank offset %0d illegal for element width %0d", bank_offset, veew);

endmodule

`default_nettype wire

// File: hdl/vector_bank.sv
`default_nettype none

module vector_bank import vex_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  logic [4:0]  vs1,
    input  logic [4:0]  vs2,
    input  logic [4:0]  vw,
    input  logic [31:0] vwdata,
    input  logic [3:0]  byte_wen,
    output logic [31:0] vdat1,
    output logic [31:0] vdat2,
    output logic [31:0] v0
);

    // One word of every vector register
    logic [31:0] regs [num_vregs];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int r = 0; r < num_vregs; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (byte_wen[i]) begin
                    regs[vw][8*i +: 8] <= vwdata[8*i +: 8];
                end
            end
        end
    end

    // Read ports are combinational
    assign vdat1 = regs[vs1];
    assign vdat2 = regs[vs2];

    // Mask register slice for the mask unit
    assign v0 = regs[0];

endmodule

`default_nettype wire

// File: hdl/vex_datapath.sv
`default_nettype none

module vex_datapath import vex_pkg::*; (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 issue,
    input  logic [3:0]           vexec,
    input  logic [4:0]           vs1_sel,
    input  logic [4:0]           vs2_sel,
    input  logic [4:0]           vd_sel,
    input  logic [1:0]           veew,
    input  logic [1:0]           bank_offset,
    input  logic                 sign_ext,
    input  logic [1:0]           src_sel,
    input  logic [31:0]          rdat1,
    input  logic [4:0]           vimm,
    input  logic                 mask_en,
    input  logic [7:0]           vl,
    input  logic                 vregwen,
    output logic [vlen-1:0]      vres,
    output logic [num_lanes-1:0] lane_mask
);

    logic [31:0]          bank_dat1 [num_lanes];
    logic [31:0]          bank_dat2 [num_lanes];
    logic [31:0]          xbar_dat1 [num_lanes];
    logic [31:0]          xbar_dat2 [num_lanes];
    logic [31:0]          op_b [num_lanes];
    logic [31:0]          lane_res [num_lanes];
    logic [31:0]          wdata [num_lanes];
    logic [3:0]           xbar_wen [num_lanes];
    logic [3:0]           bank_wen [num_lanes];
    logic [vlen-1:0]      v0;
    logic [31:0]          ext_imm;
    logic [num_lanes-1:0] lane_act;
    logic                 wr_en;

    assign ext_imm = {{27{vimm[4]}}, vimm};
    assign wr_en   = issue && vregwen;

    // Bank k holds word k of every register
    for (genvar b = 0; b < num_lanes; b++) begin : g_bank
        assign bank_wen[b] = wr_en ? xbar_wen[b] : 4'b0000;

        vector_bank u_bank (
            .CLK      (CLK),
            .rst      (rst),
            .vs1      (vs1_sel),
            .vs2      (vs2_sel),
            .vw       (vd_sel),
            .vwdata   (wdata[b]),
            .byte_wen (bank_wen[b]),
            .vdat1    (bank_dat1[b]),
            .vdat2    (bank_dat2[b]),
            .v0       (v0[32*b +: 32])
        );
    end

    read_xbar u_xbar_vs1 (.CLK(CLK), .bank_dat(bank_dat1), .veew(veew),
        .bank_offset(bank_offset), .sign_ext(sign_ext), .out_dat(xbar_dat1));

    read_xbar u_xbar_vs2 (.CLK(CLK), .bank_dat(bank_dat2), .veew(veew),
        .bank_offset(bank_offset), .sign_ext(sign_ext), .out_dat(xbar_dat2));

    for (genvar k = 0; k < num_lanes; k++) begin : g_lane
        // Scalar and immediate are broadcast to every lane
        always_comb begin
            case (src_sel)
                src_vec:    op_b[k] = xbar_dat1[k];
                src_scalar: op_b[k] = rdat1;
                src_imm:    op_b[k] = ext_imm;
                default:    op_b[k] = xbar_dat1[k];
            endcase
        end

        vfu u_vfu (.vopA(xbar_dat2[k]), .vopB(op_b[k]), .vop(vexec), .vres(lane_res[k]));
    end

    mask_unit u_mask (.v0(v0), .mask_enable(mask_en), .bank_offset(bank_offset),
        .vl(vl), .lane_mask(lane_act));

    write_xbar u_wxbar (.lane_res(lane_res), .veew(veew), .bank_offset(bank_offset),
        .lane_mask(lane_act), .wdata(wdata), .byte_wen(xbar_wen));

    // Results held until the next micro-op
    always_ff @(posedge CLK) begin
        if (rst) begin
            vres      <= '0;
            lane_mask <= '0;
        end else if (issue) begin
            for (int k = 0; k < num_lanes; k++) begin
                vres[32*k +: 32] <= lane_res[k];
            end
            lane_mask <= lane_act;
        end
    end

endmodule

`default_nettype wire

// File: hdl/vex_handshake.sv
`default_nettype none

module vex_handshake (
    input  logic CLK,
    input  logic rst,
    input  logic req,
    output logic ack,
    output logic issue
);

    // Set in the cycle after issue and raises ack
    logic pend;

    always_ff @(posedge CLK) begin
        if (rst) begin
            issue <= 1'b0;
            pend  <= 1'b0;
            ack   <= 1'b0;
        end else begin
            issue <= req && !ack && !issue && !pend;
            pend  <= issue;
            if (pend) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;
            end
        end
    end

    // No second issue before ack can rise
    assert property (@(posedge CLK) disable iff (rst) issue |-> ##1 !issue ##1 !issue)
        else $error("issue strobe repeated within one operation");

    // Ack only answers a request seen at the previous edge
    assert property (@(posedge CLK) disable iff (rst) $rose(ack) |-> $past(req))
        else $error("ack rose without req");

endmodule

`default_nettype wire

// File: hdl/vex_pkg.sv
`default_nettype none

package vex_pkg;

    // Lane and register file geometry
    localparam int num_lanes = 4;
    localparam int num_vregs = 32;
    localparam int vlen      = 128;

    // Element width codes
    localparam logic [1:0] eew_8  = 2'd0;
    localparam logic [1:0] eew_16 = 2'd1;
    localparam logic [1:0] eew_32 = 2'd2;

    // Lane ALU operations
    localparam logic [3:0] op_add  = 4'd0;
    localparam logic [3:0] op_sub  = 4'd1;
    localparam logic [3:0] op_and  = 4'd2;
    localparam logic [3:0] op_or   = 4'd3;
    localparam logic [3:0] op_xor  = 4'd4;
    localparam logic [3:0] op_sll  = 4'd5;
    localparam logic [3:0] op_srl  = 4'd6;
    localparam logic [3:0] op_sra  = 4'd7;
    // Signed compare
    localparam logic [3:0] op_min  = 4'd8;
    localparam logic [3:0] op_max  = 4'd9;
    // Unsigned compare
    localparam logic [3:0] op_minu = 4'd10;
    localparam logic [3:0] op_maxu = 4'd11;

    // Source of ALU operand B
    localparam logic [1:0] src_vec    = 2'd0;
    localparam logic [1:0] src_scalar = 2'd1;
    localparam logic [1:0] src_imm    = 2'd2;

    // One bank word, seen as a word, two halfwords or four bytes.
    // Slot 0 is always the least significant part
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] halves;
        logic [3:0][7:0]  bytes;
    } bank_word_u;

endpackage

`default_nettype wire

// File: hdl/vex_unit.sv
`default_nettype none

module vex_unit import vex_pkg::*; (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 req,
    output logic                 ack,
    input  logic [3:0]           vexec,
    input  logic [4:0]           vs1_sel,
    input  logic [4:0]           vs2_sel,
    input  logic [4:0]           vd_sel,
    input  logic [1:0]           veew,
    input  logic [1:0]           bank_offset,
    input  logic                 sign_ext,
    input  logic [1:0]           src_sel,
    input  logic [31:0]          rdat1,
    input  logic [4:0]           vimm,
    input  logic                 mask_en,
    input  logic [7:0]           vl,
    input  logic                 vregwen,
    output logic [vlen-1:0]      vres,
    output logic [num_lanes-1:0] lane_mask
);

    logic issue;

    vex_handshake u_hs (
        .CLK   (CLK),
        .rst   (rst),
        .req   (req),
        .ack   (ack),
        .issue (issue)
    );

    vex_datapath u_dp (
        .CLK         (CLK),
        .rst         (rst),
        .issue       (issue),
        .vexec       (vexec),
        .vs1_sel     (vs1_sel),
        .vs2_sel     (vs2_sel),
        .vd_sel      (vd_sel),
        .veew        (veew),
        .bank_offset (bank_offset),
        .sign_ext    (sign_ext),
        .src_sel     (src_sel),
        .rdat1       (rdat1),
        .vimm        (vimm),
        .mask_en     (mask_en),
        .vl          (vl),
        .vregwen     (vregwen),
        .vres        (vres),
        .lane_mask   (lane_mask)
    );

endmodule

`default_nettype wire

// File: hdl/vfu.sv
`default_nettype none

module vfu import vex_pkg::*; (
    input  logic [31:0] vopA,
    input  logic [31:0] vopB,
    input  logic [3:0]  vop,
    output logic [31:0] vres
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    // Only the low five bits shift
    assign shamt = vopB[4:0];

    assign lt_s = $signed(vopA) < $signed(vopB);
    assign lt_u = vopA < vopB;

    always_comb begin
        case (vop)
            op_add:  vres = vopA + vopB;
            op_sub:  vres = vopA - vopB;
            op_and:  vres = vopA & vopB;
            op_or:   vres = vopA | vopB;
            op_xor:  vres = vopA ^ vopB;
            op_sll:  vres = vopA << shamt;
            op_srl:  vres = vopA >> shamt;
            // Arithmetic shift keeps the sign of A
            op_sra:  vres = $unsigned($signed(vopA) >>> shamt);
            op_min:  vres = lt_s ? vopA : vopB;
            op_max:  vres = lt_s ? vopB : vopA;
            op_minu: vres = lt_u ? vopA : vopB;
            op_maxu: vres = lt_u ? vopB : vopA;
            default: vres = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/write_xbar.sv
`default_nettype none

module write_xbar import vex_pkg::*; (
    input  logic [31:0]          lane_res [num_lanes],
    input  logic [1:0]           veew,
    input  logic [1:0]           bank_offset,
    input  logic [num_lanes-1:0] lane_mask,
    output logic [31:0]          wdata [num_lanes],
    output logic [3:0]           byte_wen [num_lanes]
);

    bank_word_u wword [num_lanes];

    always_comb begin
        logic [3:0] idx;
        // Nothing addressed means the bank keeps its word
        for (int b = 0; b < num_lanes; b++) begin
            wword[b].word = '0;
            byte_wen[b] = 4'b0000;
        end
        for (int k = 0; k < num_lanes; k++) begin
            idx = {bank_offset, k[1:0]};
            case (veew)
                eew_8: begin
                    wword[idx[3:2]].bytes[idx[1:0]] = lane_res[k][7:0];
                    byte_wen[idx[3:2]][idx[1:0]] = lane_mask[k];
                end
                eew_16: begin
                    wword[idx[2:1]].halves[idx[0]] = lane_res[k][15:0];
                    byte_wen[idx[2:1]][2*idx[0] +: 2] = {2{lane_mask[k]}};
                end
                eew_32: begin
                    wword[idx[1:0]].word = lane_res[k];
                    byte_wen[idx[1:0]] = {4{lane_mask[k]}};
                end
                default: ;
            endcase
        end
        for (int b = 0; b < num_lanes; b++) begin
            wdata[b] = wword[b].word;
        end
    end

endmodule

`default_nettype wire

// File: tb/vex_model.svh
`ifndef VEX_MODEL_SVH
`define VEX_MODEL_SVH

// Shadow register file, element i of width w sits at bits [i*w +: w]
logic [vlen-1:0] shadow [num_vregs];

function automatic int elem_width(input logic [1:0] ew);
    return (ew == eew_8) ? 8 : (ew == eew_16) ? 16 : 32;
endfunction

function automatic logic [31:0] get_elem(input logic [127:0] vreg, input logic [1:0] ew,
                                         input int idx, input logic sx);
    int          w;
    logic [31:0] e;
    logic [31:0] keep;
    w = elem_width(ew);
    e = 32'(vreg >> (idx * w));
    if (w == 32) return e;
    keep = (32'd1 << w) - 32'd1;
    e = e & keep;
    if (sx && e[w-1]) e = e | ~keep;
    return e;
endfunction

function automatic logic [127:0] put_elem(input logic [127:0] vreg, input logic [1:0] ew,
                                          input int idx, input logic [31:0] val);
    int           w;
    logic [127:0] field;
    w = elem_width(ew);
    field = ((128'd1 << w) - 128'd1) << (idx * w);
    return (vreg & ~field) | ((128'(val) << (idx * w)) & field);
endfunction

function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] sa;
    logic [31:0] sb;
    sh = b[4:0];
    // Flipped sign bits turn the signed compare into an unsigned one
    sa = a ^ 32'h8000_0000;
    sb = b ^ 32'h8000_0000;
    case (op)
        op_add:  return a + b;
        op_sub:  return a - b;
        op_and:  return a & b;
        op_or:   return a | b;
        op_xor:  return a ^ b;
        op_sll:  return a << sh;
        op_srl:  return a >> sh;
        op_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
        op_min:  return (sa < sb) ? a : b;
        op_max:  return (sa < sb) ? b : a;
        op_minu: return (a < b) ? a : b;
        op_maxu: return (a < b) ? b : a;
        default: return 32'd0;
    endcase
endfunction

function automatic logic lane_on(input logic [127:0] v0_reg, input logic men,
                                 input logic [7:0] len, input int idx);
    return (idx < len) && (!men || v0_reg[idx]);
endfunction

`endif

// File: tb/vex_unit_tb.sv
`default_nettype none

module vex_unit_tb import vex_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_ops     = 86;
    localparam int hold_cycles = 5;

    logic                 CLK = 1'b0;
    logic                 rst;
    logic                 req;
    logic                 ack;
    logic [3:0]           vexec;
    logic [4:0]           vs1_sel;
    logic [4:0]           vs2_sel;
    logic [4:0]           vd_sel;
    logic [1:0]           veew;
    logic [1:0]           bank_offset;
    logic                 sign_ext;
    logic [1:0]           src_sel;
    logic [31:0]          rdat1;
    logic [4:0]           vimm;
    logic                 mask_en;
    logic [7:0]           vl;
    logic                 vregwen;
    logic [vlen-1:0]      vres;
    logic [num_lanes-1:0] lane_mask;

    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] lcg_state = 32'he7d1;

    `include "vex_model.svh"

    vex_unit u_dut (.*);

    always #5 CLK = ~CLK;

    // Ten cycles of 10 ns per micro-op with twice that as margin
    initial begin
        #(num_ops * 10 * 10 * 2);
        $display("watchdog expired at %0t, the handshake stopped responding", $time);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic do_op(input logic [3:0] op, input logic [4:0] vd, input logic [4:0] vs2,
                         input logic [4:0] vs1, input logic [1:0] ew, input logic [1:0] off,
                         input logic sx, input logic [1:0] src, input logic [31:0] b_val,
                         input logic wen, input int hold);
        logic [127:0] exp_res;
        logic [3:0]   exp_mask;
        logic [31:0]  a;
        logic [31:0]  b;
        int           idx;
        int           wait_cnt;
        for (int k = 0; k < num_lanes; k++) begin
            idx = off * 4 + k;
            a = get_elem(shadow[vs2], ew, idx, sx);
            case (src)
                src_scalar: b = b_val;
                src_imm:    b = 32'($signed(b_val[4:0]));
                default:    b = get_elem(shadow[vs1], ew, idx, sx);
            endcase
            exp_res[32*k +: 32] = alu_ref(op, a, b);
            exp_mask[k] = lane_on(shadow[0], mask_en, vl, idx);
        end
        check(ack, 1'b0, "ack before req");
        vexec = op;
        vd_sel = vd;
        vs2_sel = vs2;
        vs1_sel = vs1;
        veew = ew;
        bank_offset = off;
        sign_ext = sx;
        src_sel = src;
        rdat1 = b_val;
        vimm = b_val[4:0];
        vregwen = wen;
        req = 1'b1;
        wait_cnt = 0;
        do begin
            next_cycle();
            wait_cnt++;
        end while (!ack && wait_cnt < 20);
        if (!ack) begin
            $display("handshake error at %0t: ack did not rise after req", $time);
            errors++;
        end else begin
            check(vres, exp_res, "result");
            check(lane_mask, exp_mask, "lane mask");
            repeat (hold) begin
                next_cycle();
                check(ack, 1'b1, "ack while req held");
                check(vres, exp_res, "result while req held");
                check(lane_mask, exp_mask, "lane mask while req held");
            end
        end
        req = 1'b0;
        wait_cnt = 0;
        while (ack && wait_cnt < 20) begin
            next_cycle();
            wait_cnt++;
        end
        if (ack) begin
            $display("handshake error at %0t: ack stayed high after req fell", $time);
            errors++;
        end
        if (wen) begin
            for (int k = 0; k < num_lanes; k++) begin
                if (exp_mask[k])
                    shadow[vd] = put_elem(shadow[vd], ew, off * 4 + k, exp_res[32*k +: 32]);
            end
        end
    endtask

    task automatic read_back(input logic [4:0] r);
        do_op(op_or, 5'd0, r, 5'd0, eew_32, 2'd0, 1'b0, src_imm, 32'd0, 1'b0, 0);
        check(vres, shadow[r], "readback");
    endtask

    task automatic finish_test(input string name, input int start_err);
        if (errors == start_err) begin
            $display("%s: pass", name);
            tests_passed++;
        end else begin
            $display("%s: %0d mismatches", name, errors - start_err);
            tests_failed++;
        end
    endtask

    task automatic after_reset();
        int start_err;
        start_err = errors;
        check(ack, 1'b0, "ack after reset");
        check(vres, 128'd0, "result after reset");
        check(lane_mask, 4'd0, "lane mask after reset");
        do_op(op_or, 5'd9, 5'd5, 5'd0, eew_32, 2'd0, 1'b0, src_imm, 32'd0, 1'b0, 0);
        do_op(op_or, 5'd9, 5'd3, 5'd7, eew_32, 2'd0, 1'b0, src_vec, 32'd0, 1'b0, 0);
        check(vres, 128'd0, "or of cleared registers");
        finish_test("after_reset", start_err);
    endtask

    task automatic handshake_hold();
        int start_err;
        start_err = errors;
        // A second write would add the scalar twice
        do_op(op_add, 5'd1, 5'd1, 5'd0, eew_32, 2'd0, 1'b0, src_scalar, next_rand(), 1'b1,
              hold_cycles);
        read_back(5'd1);
        finish_test("handshake_hold", start_err);
    endtask

    task automatic full_word_ops();
        int start_err;
        start_err = errors;
        for (int r = 1; r <= 8; r++) begin
            do_op(op_add, 5'(r), 5'(r), 5'd0, eew_32, 2'd0, 1'b0, src_scalar, next_rand(),
                  1'b1, 0);
        end
        for (int r = 1; r <= 8; r++) begin
            do_op(op_xor, 5'(r), 5'(r), 5'd0, eew_8, 2'(r), 1'b0, src_scalar, next_rand(),
                  1'b1, 0);
        end
        // Op codes 0 to 11 in order
        for (int i = 0; i < 12; i++) begin
            do_op(4'(i), 5'(10 + i), 5'(1 + i % 8), 5'(1 + (i + 3) % 8), eew_32, 2'd0, 1'b0,
                  src_vec, 32'd0, 1'b1, 0);
        end
        finish_test("full_word_ops", start_err);
    endtask

    task automatic narrow_elements();
        int start_err;
        int j;
        start_err = errors;
        j = 0;
        do_op(op_add, 5'd20, 5'd20, 5'd0, eew_32, 2'd0, 1'b0, src_scalar, next_rand(), 1'b1, 0);
        for (int s = 0; s < 2; s++) begin
            for (int o = 0; o < 4; o++) begin
                do_op(4'((j * 5) % 12), 5'd20, 5'd2, 5'd3, eew_8, 2'(o), 1'(s), src_vec,
                      32'd0, 1'b1, 0);
                read_back(5'd20);
                j++;
            end
            for (int o = 0; o < 2; o++) begin
                do_op(4'((j * 5) % 12), 5'd20, 5'd3, 5'd4, eew_16, 2'(o), 1'(s), src_vec,
                      32'd0, 1'b1, 0);
                read_back(5'd20);
                j++;
            end
        end
        finish_test("narrow_elements", start_err);
    endtask

    task automatic lane_masking();
        int start_err;
        start_err = errors;
        do_op(op_add, 5'd0, 5'd0, 5'd0, eew_32, 2'd0, 1'b0, src_scalar, next_rand(), 1'b1, 0);
        do_op(op_add, 5'd21, 5'd21, 5'd0, eew_32, 2'd0, 1'b0, src_scalar, next_rand(), 1'b1, 0);
        for (int i = 0; i < 8; i++) begin
            mask_en = 1'(i % 2);
            vl = 8'(next_rand() % 17);
            do_op(op_sub, 5'd21, 5'd4, 5'd5, eew_8, 2'(i % 4), 1'b0, src_vec, 32'd0, 1'b1, 0);
            read_back(5'd21);
        end
        mask_en = 1'b1;
        vl = 8'd2;
        do_op(op_max, 5'd21, 5'd6, 5'd7, eew_32, 2'd0, 1'b1, src_vec, 32'd0, 1'b1, 0);
        mask_en = 1'b0;
        vl = 8'd16;
        read_back(5'd21);
        finish_test("lane_masking", start_err);
    endtask

    task automatic operand_select();
        int         start_err;
        logic [4:0] imm_vals [4];
        start_err = errors;
        imm_vals = '{5'h10, 5'h1f, 5'h07, 5'h13};
        for (int i = 0; i < 4; i++) begin
            do_op(4'(i * 3), 5'd22, 5'd6, 5'd0, eew_16, 2'(i % 2), 1'(i / 2), src_scalar,
                  next_rand(), 1'b1, 0);
            do_op(4'(i * 3 + 1), 5'd22, 5'd7, 5'd0, eew_32, 2'd0, 1'b0, src_imm,
                  {27'd0, imm_vals[i]}, 1'b1, 0);
        end
        read_back(5'd22);
        finish_test("operand_select", start_err);
    endtask

    initial begin
        rst = 1'b1;
        req = 1'b0;
        vexec = '0;
        vs1_sel = '0;
        vs2_sel = '0;
        vd_sel = '0;
        veew = eew_32;
        bank_offset = '0;
        sign_ext = 1'b0;
        src_sel = src_vec;
        rdat1 = '0;
        vimm = '0;
        mask_en = 1'b0;
        vl = 8'd16;
        vregwen = 1'b0;
        for (int r = 0; r < num_vregs; r++) begin
            shadow[r] = '0;
        end
        repeat (2) @(posedge CLK);
        #1;
        rst = 1'b0;
        after_reset();
        handshake_hold();
        full_word_ops();
        narrow_elements();
        lane_masking();
        operand_select();
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vex.f
+incdir+tb
hdl/vex_pkg.sv
hdl/vector_bank.sv
hdl/read_xbar.sv
hdl/write_xbar.sv
hdl/vfu.sv
hdl/mask_unit.sv
hdl/vex_datapath.sv
hdl/vex_handshake.sv
hdl/vex_unit.sv
tb/vex_unit_tb.sv
